// File: sources.f
arp_pkg.sv
arp_config_regs.sv
arp_rx_parser.sv
arp_reply_tx.sv
arp_responder.sv
tb_arp_responder.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ARP responder testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_arp_responder \
	-f sources.f \
	-Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Simulation FAILED" "$log"; then
	echo "testbench reported a failure"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if ! grep -q "Simulation PASSED" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi

exit 0

// File: tb_arp_responder.sv
`timescale 1ns/10ps

module tb_arp_responder
	import arp_pkg::*;
();

	localparam int clk_period     = 40;
	localparam int frame_cycles   = 60;
	localparam int reply_delay_ns = (3 + reply_gap + 1) * clk_period + clk_period / 2;

	logic        clk;
	logic        reset;
	logic        rx_new_frame_head;
	logic [15:0] rx_ethertype;
	logic        rx_dven;
	logic [7:0]  rx_data;
	logic        rx_crc_zero;
	logic        tx_dven;
	logic [7:0]  tx_data;
	logic [47:0] tx_smac;
	logic [47:0] tx_dmac;
	logic [15:0] tx_ethertype;
	logic        cfg_we;
	cfg_addr_t   cfg_addr;
	logic [31:0] cfg_wdata;
	logic [31:0] cfg_rdata;

	integer                  seed;
	logic [arp_head_len*8-1:0] exp_head; // modelled reply header.
	logic [47:0]             exp_smac;
	logic [47:0]             exp_dmac;
	logic                    armed;
	logic                    fall_recorded;
	time                     fall_time;
	int                      byte_idx;
	int                      replies_seen;
	logic [47:0]             local_mac;
	logic [31:0]             local_ip;
	logic [31:0]             old_ip;
	logic [47:0]             sha;
	logic [31:0]             spa;

	arp_responder uut (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial begin
		#((40 * frame_cycles + 200) * clk_period);
		$display("Watchdog expired: the tests did not finish in time");
		$display("Simulation FAILED");
		$fatal(1);
	end

	// ############################################################
	// error reporting and checks
	// ############################################################

	task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
		$display("Fail %0d ns: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic plain_error(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else value_error(name, exp, act);
	endtask

	a_idle_smac: assert property (@(posedge clk) !tx_dven |-> tx_smac == 48'd0)
		else value_error("tx_smac", 0, $sampled(tx_smac));
	a_idle_dmac: assert property (@(posedge clk) !tx_dven |-> tx_dmac == 48'd0)
		else value_error("tx_dmac", 0, $sampled(tx_dmac));
	a_idle_type: assert property (@(posedge clk) !tx_dven |-> tx_ethertype == 16'd0)
		else value_error("tx_ethertype", 0, $sampled(tx_ethertype));
	a_busy_type: assert property (@(posedge clk) tx_dven |-> tx_ethertype == ethertype_arp)
		else value_error("tx_ethertype", ethertype_arp, $sampled(tx_ethertype));
	a_reset_quiet: assert property (@(posedge clk) reset |-> !tx_dven)
		else value_error("tx_dven", 0, $sampled(tx_dven));

	// reply collector, sampled mid cycle.
	always @(negedge clk) begin
		if (tx_dven) begin
			if (!armed)
				plain_error("Unexpected reply: tx_dven rose without an accepted request");
			else if (byte_idx >= arp_head_len)
				plain_error("tx_dven stayed high longer than one ARP header");
			else begin
				if (byte_idx == 0)
					check_value("tx_dven delay in ns", reply_delay_ns, $time - fall_time);
				check_value($sformatf("tx_data[%0d]", byte_idx),
					exp_head[arp_head_len*8-1-8*byte_idx -: 8], tx_data);
				check_value("tx_dmac", exp_dmac, tx_dmac);
				check_value("tx_smac", exp_smac, tx_smac);
				byte_idx = byte_idx + 1;
			end
		end else if (byte_idx != 0) begin
			check_value("tx_dven length", arp_head_len, byte_idx);
			byte_idx = 0;
			armed = 1'b0;
			replies_seen = replies_seen + 1;
		end
	end

	// ############################################################
	// stimulus tasks
	// ############################################################

	task automatic cfg_write(input cfg_addr_t addr, input logic [31:0] data);
		@(posedge clk);
		cfg_we    <= 1'b1;
		cfg_addr  <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	task automatic cfg_read_check(input cfg_addr_t addr, input logic [31:0] exp);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		check_value($sformatf("cfg_rdata[%s]", addr.name()), exp, cfg_rdata);
	endtask

	task automatic new_requester();
		sha = {16'($random(seed)), 32'($random(seed))};
		spa = $random(seed);
	endtask

	// expected reply from the current station identity.
	task automatic arm_reply(input logic [47:0] tha, input logic [31:0] tpa);
		exp_head = {arp_htype_eth, arp_ptype_ipv4, arp_hlen, arp_plen, 16'd2,
			local_mac, local_ip, tha, tpa};
		exp_smac = local_mac;
		exp_dmac = tha;
		fall_recorded = 1'b0;
		armed = 1'b1;
	endtask

	task automatic send_frame(input logic [15:0] etype, input logic [15:0] oper,
		input logic [47:0] s_ha, input logic [31:0] s_pa, input logic [31:0] t_pa,
		input logic crc_good, input int pad_len);
		logic [arp_head_len*8-1:0] head;
		int i;
		head = {arp_htype_eth, arp_ptype_ipv4, arp_hlen, arp_plen, oper, s_ha, s_pa, 48'd0, t_pa};
		for (i = 0; i < arp_head_len + pad_len; i++) begin
			@(posedge clk);
			rx_new_frame_head <= (i == 0); // head pulse rides on the first byte.
			rx_ethertype      <= etype;
			rx_crc_zero       <= 1'b0;
			rx_dven           <= 1'b1;
			rx_data           <= (i < arp_head_len) ? head[arp_head_len*8-1-8*i -: 8] : 8'h00;
		end
		@(posedge clk);
		rx_new_frame_head <= 1'b0;
		rx_dven           <= 1'b0;
		rx_data           <= 8'h00;
		if (armed && !fall_recorded) begin
			fall_time     = $time;
			fall_recorded = 1'b1;
		end
		@(posedge clk);
		rx_crc_zero <= crc_good;
	endtask

	task automatic wait_replies(input int count);
		int n;
		n = 0;
		while (replies_seen < count) begin
			@(negedge clk);
			n++;
			if (n > frame_cycles)
				plain_error("Timeout: the expected reply did not complete on tx_dven");
		end
	endtask

	task automatic wait_reply_start();
		int n;
		n = 0;
		while (byte_idx == 0) begin
			@(negedge clk);
			n++;
			if (n > frame_cycles)
				plain_error("Timeout: the expected reply did not start on tx_dven");
		end
	endtask

	// ############################################################
	// test sequence
	// ############################################################

	initial begin
		int a;
		seed = 81;
		reset = 1'b1;
		rx_new_frame_head = 1'b0;
		rx_ethertype = 16'd0;
		rx_dven = 1'b0;
		rx_data = 8'd0;
		rx_crc_zero = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = cfg_mac_hi;
		cfg_wdata = 32'd0;
		armed = 1'b0;
		fall_recorded = 1'b0;
		fall_time = 0;
		byte_idx = 0;
		replies_seen = 0;
		local_mac = 48'h02_1a_2b_3c_4d_5e;
		local_ip = 32'hc0a8_0a07;

		@(posedge clk);
		cfg_addr <= cfg_ip;
		@(negedge clk);
		check_value("tx_dven", 0, tx_dven);
		check_value("cfg_rdata[cfg_ip]", 0, cfg_rdata);
		@(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("tx_dven", 0, tx_dven);
		for (a = 0; a < 6; a++)
			cfg_read_check(cfg_addr_t'(a), 32'd0);

		cfg_write(cfg_mac_hi, {16'hffff, local_mac[47:32]}); // upper bits must read zero.
		cfg_write(cfg_mac_lo, local_mac[31:0]);
		cfg_write(cfg_ip, local_ip);
		cfg_write(cfg_ctrl, 32'h0000_0001);
		cfg_write(cfg_reply_count, 32'h0000_1234);
		cfg_write(cfg_drop_count, 32'h0000_5678);
		cfg_read_check(cfg_mac_hi, {16'd0, local_mac[47:32]});
		cfg_read_check(cfg_mac_lo, local_mac[31:0]);
		cfg_read_check(cfg_ip, local_ip);
		cfg_read_check(cfg_ctrl, 32'd1);
		cfg_read_check(cfg_reply_count, 32'd0);
		cfg_read_check(cfg_drop_count, 32'd0);

		new_requester();
		arm_reply(sha, spa);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 18);
		wait_replies(1);
		cfg_read_check(cfg_reply_count, 32'd1);

		// none of these may answer.
		new_requester();
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip ^ 32'h1, 1'b1, 18);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b0, 18);
		send_frame(ethertype_arp, oper_reply, sha, spa, local_ip, 1'b1, 18);
		send_frame(16'h0800, oper_request, sha, spa, local_ip, 1'b1, 18);
		cfg_write(cfg_ctrl, 32'd0);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 18);
		repeat (40) @(negedge clk);
		cfg_write(cfg_ctrl, 32'd1);
		cfg_read_check(cfg_reply_count, 32'd1);

		// second request lands on the last reply byte.
		new_requester();
		arm_reply(sha, spa);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 18);
		new_requester();
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 0);
		wait_replies(2);
		repeat (40) @(negedge clk);
		cfg_read_check(cfg_drop_count, 32'd1);
		cfg_read_check(cfg_reply_count, 32'd2);

		old_ip = local_ip;
		new_requester();
		arm_reply(sha, spa);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 18);
		wait_reply_start();
		local_ip = 32'hc0a8_0a63;
		cfg_write(cfg_ip, local_ip);
		wait_replies(3);
		new_requester();
		arm_reply(sha, spa);
		send_frame(ethertype_arp, oper_request, sha, spa, local_ip, 1'b1, 18);
		wait_replies(4);
		send_frame(ethertype_arp, oper_request, sha, spa, old_ip, 1'b1, 18);
		repeat (40) @(negedge clk);
		cfg_read_check(cfg_reply_count, 32'd4);
		cfg_read_check(cfg_drop_count, 32'd1);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: arp_responder.sv
`timescale 1ns/10ps

module arp_responder
	import arp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	// mac receive side.
	input  logic        rx_new_frame_head,
	input  logic [15:0] rx_ethertype,
	input  logic        rx_dven,
	input  logic [7:0]  rx_data,
	input  logic        rx_crc_zero,
	// mac transmit side.
	output logic        tx_dven,
	output logic [7:0]  tx_data,
	output logic [47:0] tx_smac,
	output logic [47:0] tx_dmac,
	output logic [15:0] tx_ethertype,
	// register bus.
	input  logic        cfg_we,
	input  cfg_addr_t   cfg_addr,
	input  logic [31:0] cfg_wdata,
	output logic [31:0] cfg_rdata
);

	logic [47:0] local_mac;
	logic [31:0] local_ip;
	logic        enable;
	logic        req_accept;
	logic [47:0] req_sha;
	logic [31:0] req_spa;
	logic        reply_sent;
	logic        req_dropped;

	arp_config_regs regs (
		.clk         (clk),
		.reset       (reset),
		.cfg_we      (cfg_we),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.cfg_rdata   (cfg_rdata),
		.reply_sent  (reply_sent),
		.req_dropped (req_dropped),
		.local_mac   (local_mac),
		.local_ip    (local_ip),
		.enable      (enable)
	);

	arp_rx_parser parser (
		.clk               (clk),
		.reset             (reset),
		.rx_new_frame_head (rx_new_frame_head),
		.rx_ethertype      (rx_ethertype),
		.rx_dven           (rx_dven),
		.rx_data           (rx_data),
		.rx_crc_zero       (rx_crc_zero),
		.local_ip          (local_ip),
		.enable            (enable),
		.req_accept        (req_accept),
		.req_sha           (req_sha),
		.req_spa           (req_spa)
	);

	arp_reply_tx reply (
		.clk          (clk),
		.reset        (reset),
		.req_accept   (req_accept),
		.req_sha      (req_sha),
		.req_spa      (req_spa),
		.local_mac    (local_mac),
		.local_ip     (local_ip),
		.tx_dven      (tx_dven),
		.tx_data      (tx_data),
		.tx_smac      (tx_smac),
		.tx_dmac      (tx_dmac),
		.tx_ethertype (tx_ethertype),
		.reply_sent   (reply_sent),
		.req_dropped  (req_dropped)
	);

endmodule

// File: arp_reply_tx.sv
`timescale 1ns/10ps

module arp_reply_tx
	import arp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        req_accept,
	input  logic [47:0] req_sha,
	input  logic [31:0] req_spa,
	input  logic [47:0] local_mac,
	input  logic [31:0] local_ip,
	output logic        tx_dven,
	output logic [7:0]  tx_data,
	output logic [47:0] tx_smac,
	output logic [47:0] tx_dmac,
	output logic [15:0] tx_ethertype,
	output logic        reply_sent,
	output logic        req_dropped
);

	logic                     pending;
	logic                     busy;
	logic                     start;
	logic [1:0]               gap_cnt;
	logic [4:0]               byte_cnt;
	logic                     last_byte;
	logic [47:0]              sha_q;
	logic [31:0]              spa_q;
	logic [47:0]              tha_q;
	logic [31:0]              tpa_q;
	logic [arp_head_bits-1:0] reply_head;

	assign busy      = pending || tx_dven;
	assign start     = req_accept && !busy;
	assign last_byte = tx_dven && (byte_cnt == 5'(arp_head_len - 1));

	// ############################################################
	// field latch
	// ############################################################

	// identity is frozen here for the whole reply.
	always_ff @(posedge clk) begin
		if (start) begin
			tha_q <= req_sha;
			tpa_q <= req_spa;
			sha_q <= local_mac;
			spa_q <= local_ip;
		end
	end

	assign reply_head = {arp_htype_eth, arp_ptype_ipv4, arp_hlen, arp_plen,
		16'(oper_reply), sha_q, spa_q, tha_q, tpa_q};

	// ############################################################
	// byte sequencer
	// ############################################################

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pending  <= 1'b0;
			tx_dven  <= 1'b0;
			gap_cnt  <= '0;
			byte_cnt <= '0;
		end else if (start) begin
			pending <= 1'b1;
			gap_cnt <= '0;
		end else if (pending) begin
			if (gap_cnt == 2'(reply_gap - 1)) begin
				pending  <= 1'b0;
				tx_dven  <= 1'b1;
				byte_cnt <= '0;
			end else begin
				gap_cnt <= gap_cnt + 2'd1;
			end
		end else if (tx_dven) begin
			if (last_byte)
				tx_dven <= 1'b0;
			else
				byte_cnt <= byte_cnt + 5'd1;
		end
	end

	// msb first.
	assign tx_data = tx_dven ? reply_head[8*(arp_head_len-1-int'(byte_cnt)) +: 8] : 8'd0;

	assign tx_smac      = tx_dven ? sha_q : 48'd0;
	assign tx_dmac      = tx_dven ? tha_q : 48'd0;
	assign tx_ethertype = tx_dven ? ethertype_arp : 16'd0;

	assign reply_sent  = last_byte;
	assign req_dropped = req_accept && busy; // no back-pressure, so overlap is lost.

endmodule

// File: arp_rx_parser.sv
`timescale 1ns/10ps

module arp_rx_parser
	import arp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        rx_new_frame_head,
	input  logic [15:0] rx_ethertype,
	input  logic        rx_dven,
	input  logic [7:0]  rx_data,
	input  logic        rx_crc_zero,
	input  logic [31:0] local_ip,
	input  logic        enable,
	output logic        req_accept,
	output logic [47:0] req_sha,
	output logic [31:0] req_spa
);

	// ############################################################
	// input register stage
	// ############################################################

	logic        head_r;
	logic [15:0] ethertype_r;
	logic        dven_r;
	logic [7:0]  data_r;
	logic        crc_zero_r;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			head_r     <= 1'b0;
			dven_r     <= 1'b0;
			crc_zero_r <= 1'b0;
		end else begin
			head_r     <= rx_new_frame_head;
			dven_r     <= rx_dven;
			crc_zero_r <= rx_crc_zero;
		end
	end

	always_ff @(posedge clk) begin
		ethertype_r <= rx_ethertype;
		data_r      <= rx_data;
	end

	// ############################################################
	// frame state machine
	// ############################################################

	rx_state_t                  state;
	rx_state_t                  state_next;
	logic [4:0]                 byte_cnt;
	logic [arp_head_bits-1:0]   header;
	logic                       arp_head;
	logic                       take_byte;
	logic                       last_byte;

	assign arp_head  = head_r && (ethertype_r == ethertype_arp);
	// a byte may arrive together with the head pulse.
	assign take_byte = dven_r && (state == rx_head || (state == rx_idle && arp_head));
	assign last_byte = take_byte && (byte_cnt == 5'(arp_head_len - 1));

	always_comb begin
		state_next = state;
		case (state)
			rx_idle: begin
				if (arp_head)
					state_next = rx_head;
			end
			rx_head: begin
				if (last_byte)
					state_next = rx_payload;
				else if (!dven_r && byte_cnt != 5'd0)
					state_next = rx_idle; // runt frame.
			end
			rx_payload: begin
				if (!dven_r)
					state_next = rx_tail;
			end
			rx_tail: state_next = rx_idle;
			default: state_next = rx_idle;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state    <= rx_idle;
			byte_cnt <= '0;
		end else begin
			state <= state_next;
			if (state_next != rx_head)
				byte_cnt <= '0;
			else if (take_byte)
				byte_cnt <= byte_cnt + 5'd1;
		end
	end

	// first byte ends up in the top bits.
	always_ff @(posedge clk) begin
		if (take_byte)
			header <= {header[arp_head_bits-9:0], data_r};
	end

	// ############################################################
	// judgement
	// ############################################################

	logic [31:0] req_tpa;
	arp_oper_t   req_oper;
	logic        for_us;

	assign req_oper = arp_oper_t'(header[head_oper_lsb +: 16]);
	assign req_tpa  = header[head_tpa_lsb +: 32];
	assign req_sha  = header[head_sha_lsb +: 48];
	assign req_spa  = header[head_spa_lsb +: 32];

	assign for_us = enable && crc_zero_r && (req_oper == oper_request) && (req_tpa == local_ip);

	always_ff @(posedge clk or posedge reset) begin
		if (reset)
			req_accept <= 1'b0;
		else
			req_accept <= (state == rx_tail) && for_us;
	end

endmodule

// File: arp_config_regs.sv
`timescale 1ns/10ps

module arp_config_regs
	import arp_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	input  logic        cfg_we,
	input  cfg_addr_t   cfg_addr,
	input  logic [31:0] cfg_wdata,
	output logic [31:0] cfg_rdata,
	input  logic        reply_sent,
	input  logic        req_dropped,
	output logic [47:0] local_mac,
	output logic [31:0] local_ip,
	output logic        enable
);

	logic [15:0] mac_hi;
	logic [31:0] mac_lo;
	logic [15:0] reply_count;
	logic [15:0] drop_count;

	// station identity and control.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			mac_hi   <= '0;
			mac_lo   <= '0;
			local_ip <= '0;
			enable   <= 1'b0;
		end else if (cfg_we) begin
			case (cfg_addr)
				cfg_mac_hi: mac_hi   <= cfg_wdata[15:0];
				cfg_mac_lo: mac_lo   <= cfg_wdata;
				cfg_ip:     local_ip <= cfg_wdata;
				cfg_ctrl:   enable   <= cfg_wdata[0];
				default:    ; // counters are read only.
			endcase
		end
	end

	assign local_mac = {mac_hi, mac_lo};

	// saturating event counters.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reply_count <= '0;
			drop_count  <= '0;
		end else begin
			if (reply_sent && reply_count != 16'hffff)
				reply_count <= reply_count + 16'd1;
			if (req_dropped && drop_count != 16'hffff)
				drop_count <= drop_count + 16'd1;
		end
	end

	always_comb begin
		case (cfg_addr)
			cfg_mac_hi:      cfg_rdata = {16'd0, mac_hi};
			cfg_mac_lo:      cfg_rdata = mac_lo;
			cfg_ip:          cfg_rdata = local_ip;
			cfg_ctrl:        cfg_rdata = {31'd0, enable};
			cfg_reply_count: cfg_rdata = {16'd0, reply_count};
			cfg_drop_count:  cfg_rdata = {16'd0, drop_count};
			default:         cfg_rdata = '0;
		endcase
	end

endmodule

// File: arp_pkg.sv
package arp_pkg;

	// ############################################################
	// frame and header sizes
	// ############################################################

	localparam int arp_head_len  = 28;                // ARP header bytes.
	localparam int arp_head_bits = arp_head_len * 8;
	localparam int reply_gap     = 2;                 // idle cycles before first tx byte.

	// bit offsets inside the shifted-in header, first byte on top.
	localparam int head_oper_lsb = 160;
	localparam int head_sha_lsb  = 112;
	localparam int head_spa_lsb  = 80;
	localparam int head_tpa_lsb  = 0;

	// ############################################################
	// fixed protocol fields
	// ############################################################

	localparam logic [15:0] ethertype_arp  = 16'h0806;
	localparam logic [15:0] arp_htype_eth  = 16'h0001;
	localparam logic [15:0] arp_ptype_ipv4 = 16'h0800;
	localparam logic [7:0]  arp_hlen       = 8'd6;
	localparam logic [7:0]  arp_plen       = 8'd4;

	typedef enum logic [15:0] {
		oper_request = 16'd1,
		oper_reply   = 16'd2
	} arp_oper_t;

	// ############################################################
	// receive state and register map
	// ############################################################

	typedef enum logic [1:0] {
		rx_idle,
		rx_head,    // collecting header bytes.
		rx_payload, // padding until dven drops.
		rx_tail     // judgement cycle.
	} rx_state_t;

	typedef enum logic [2:0] {
		cfg_mac_hi      = 3'd0,
		cfg_mac_lo      = 3'd1,
		cfg_ip          = 3'd2,
		cfg_ctrl        = 3'd3,
		cfg_reply_count = 3'd4,
		cfg_drop_count  = 3'd5
	} cfg_addr_t;

endpackage
